/* project.f */
hdl/pcxt_glue_pkg.sv
hdl/sync_chain.sv
hdl/rate_strobe.sv
hdl/reset_sequencer.sv
hdl/cpu_clock_gen.sv
hdl/cpu_bus_glue.sv
hdl/video_option_decode.sv
hdl/pcxt_glue_top.sv
verif/pcxt_glue_properties.sv
verif/pcxt_glue_tb.sv

/* verif/pcxt_glue_tb.sv */
// PC/XT glue testbench: directed checks of reset, clock enables, synchronizers, bus and video
`timescale 1ns/1ps

module pcxt_glue_tb;

	// About 270k cycles of tests plus margin
	localparam int TIMEOUT_CYCLES = 400_000;

	logic                          CLK_50M;
	logic                          reset_wire;
	pcxt_glue_pkg::glue_settings_t settings;
	pcxt_glue_pkg::reset_req_t     reset_req;
	logic                          bus_idle;
	logic                          ale;
	logic                          opl2_ref;
	pcxt_glue_pkg::addr_t          cpu_ad;
	logic [7:0]                    port_b;
	pcxt_glue_pkg::ps2_lines_t     ps2_raw;
	logic                          sys_reset;
	logic                          cpu_reset;
	logic                          cpu_cen;
	logic                          turbo_mode;
	logic                          periph_cen;
	logic                          audio_cen;
	logic                          opl2_cen;
	pcxt_glue_pkg::addr_t          cpu_address;
	logic [3:0]                    port_c_sw;
	pcxt_glue_pkg::ps2_lines_t     ps2_sync;
	pcxt_glue_pkg::video_ctrl_t    video_ctrl;

	// Strobe values one cycle back
	logic audio_cen_q;
	logic periph_cen_q;
	logic cpu_cen_q;

	int          error_count = 0;
	int          cycle_count = 0;
	int unsigned seed;
	int unsigned seed_ret;

	pcxt_glue_top uut (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.settings    (settings),
		.reset_req   (reset_req),
		.bus_idle    (bus_idle),
		.ale         (ale),
		.opl2_ref    (opl2_ref),
		.cpu_ad      (cpu_ad),
		.port_b      (port_b),
		.ps2_raw     (ps2_raw),
		.sys_reset   (sys_reset),
		.cpu_reset   (cpu_reset),
		.cpu_cen     (cpu_cen),
		.turbo_mode  (turbo_mode),
		.periph_cen  (periph_cen),
		.audio_cen   (audio_cen),
		.opl2_cen    (opl2_cen),
		.cpu_address (cpu_address),
		.port_c_sw   (port_c_sw),
		.ps2_sync    (ps2_sync),
		.video_ctrl  (video_ctrl)
	);

	// 50 MHz master clock
	always #10 CLK_50M = ~CLK_50M;

	// Watchdog
	always @(posedge CLK_50M) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles, tests did not finish", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Strobe width and reset ordering, sampled mid-cycle
	always @(negedge CLK_50M) begin
		if (reset_wire === 1'b0) begin
			if (audio_cen === 1'b1 && audio_cen_q === 1'b1) begin
				$display("audio_cen high on two consecutive cycles at %0d ns", $time);
				error_count++;
			end
			if (periph_cen === 1'b1 && periph_cen_q === 1'b1) begin
				$display("periph_cen high on two consecutive cycles at %0d ns", $time);
				error_count++;
			end
			if (cpu_cen === 1'b1 && cpu_cen_q === 1'b1) begin
				$display("cpu_cen high on two consecutive cycles at %0d ns", $time);
				error_count++;
			end
			if (sys_reset === 1'b1 && cpu_reset !== 1'b1) begin
				$display("cpu_reset low while sys_reset high at %0d ns", $time);
				error_count++;
			end
			if (sys_reset === 1'b1 && turbo_mode !== 1'b0) begin
				$display("turbo_mode high while sys_reset high at %0d ns", $time);
				error_count++;
			end
		end
		audio_cen_q  <= audio_cen;
		periph_cen_q <= periph_cen;
		cpu_cen_q    <= cpu_cen;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Inputs change and outputs are read 2 ns after the edge
	task automatic tick();
		@(posedge CLK_50M);
		#2;
	endtask

	task automatic report_mismatch(input string name, input longint expected,
		input longint actual);
		$display("** Error at %0d ns: %s expected %0d actual %0d", $time, name, expected, actual);
		error_count++;
	endtask

	// Pulse count allowed one off either way
	task automatic check_count(input string name, input int expected, input int actual);
		if (actual < expected - 1 || actual > expected + 1) begin
			report_mismatch(name, expected, actual);
		end
	endtask

	// Floor of cycles * step / master rate
	function automatic int expected_pulses(input int cycles, input logic [31:0] step);
		longint prod;
		prod = longint'(cycles) * longint'(step);
		return int'(prod / longint'(pcxt_glue_pkg::CLK_HZ));
	endfunction

	// All three fractional strobes counted together
	task automatic count_strobes(input int cycles, output int n_cpu, output int n_audio,
		output int n_periph);
		n_cpu    = 0;
		n_audio  = 0;
		n_periph = 0;
		repeat (cycles) begin
			tick();
			n_cpu    += int'(cpu_cen);
			n_audio  += int'(audio_cen);
			n_periph += int'(periph_cen);
		end
	endtask

	// Cycles until sys_reset drops, then until cpu_reset drops
	task automatic measure_reset_release(input string source);
		int n;
		n = 0;
		while (sys_reset === 1'b1 && n < 70_000) begin
			tick();
			n++;
		end
		if (n < pcxt_glue_pkg::RESET_STRETCH - 1 || n > pcxt_glue_pkg::RESET_STRETCH + 3) begin
			report_mismatch({"sys_reset release cycles after ", source},
				pcxt_glue_pkg::RESET_STRETCH + 1, n);
		end
		n = 0;
		while (cpu_reset === 1'b1 && n < 200) begin
			tick();
			n++;
		end
		if (n < pcxt_glue_pkg::CPU_RESET_DELAY || n > pcxt_glue_pkg::CPU_RESET_DELAY + 3) begin
			report_mismatch({"cpu_reset delay cycles after ", source},
				pcxt_glue_pkg::CPU_RESET_DELAY, n);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_sequence();
		if (sys_reset !== 1'b1 || cpu_reset !== 1'b1) begin
			$display("Reset outputs not held while reset_wire is high");
			error_count++;
		end
		reset_wire = 1'b0;
		measure_reset_release("reset_wire");
		// Turbo on before the soft reset
		settings.cpu_speed = pcxt_glue_pkg::speed_fast;
		bus_idle           = 1'b1;
		tick();
		bus_idle = 1'b0;
		if (turbo_mode !== 1'b1) begin
			report_mismatch("turbo_mode before menu_reset", 1, turbo_mode);
		end
		// One-cycle menu request
		reset_req.menu_reset = 1'b1;
		tick();
		reset_req.menu_reset = 1'b0;
		tick();
		if (sys_reset !== 1'b1) begin
			report_mismatch("sys_reset after menu_reset", 1, sys_reset);
		end
		if (cpu_reset !== 1'b1) begin
			report_mismatch("cpu_reset after menu_reset", 1, cpu_reset);
		end
		if (turbo_mode !== 1'b0) begin
			report_mismatch("turbo_mode after menu_reset", 0, turbo_mode);
		end
		measure_reset_release("menu_reset");
	endtask

	task automatic run_speed(input pcxt_glue_pkg::cpu_speed_t speed, input logic pulse_idle,
		input logic [31:0] exp_step, input logic exp_turbo);
		int n_cpu;
		int n_audio;
		int n_periph;
		settings.cpu_speed = speed;
		if (pulse_idle) begin
			bus_idle = 1'b1;
			tick();
			bus_idle = 1'b0;
		end
		repeat (2) tick();
		if (turbo_mode !== exp_turbo) begin
			report_mismatch($sformatf("turbo_mode at speed %0d", speed), exp_turbo, turbo_mode);
		end
		count_strobes(10_000, n_cpu, n_audio, n_periph);
		check_count($sformatf("cpu_cen count at speed %0d", speed),
			expected_pulses(10_000, exp_step), n_cpu);
	endtask

	task automatic test_cpu_speed();
		run_speed(pcxt_glue_pkg::speed_slow, 1'b1, pcxt_glue_pkg::CPU_STEP_SLOW, 1'b0);
		run_speed(pcxt_glue_pkg::speed_mid, 1'b1, pcxt_glue_pkg::CPU_STEP_MID, 1'b1);
		run_speed(pcxt_glue_pkg::speed_fast, 1'b1, pcxt_glue_pkg::CPU_STEP_FAST, 1'b1);
		// No idle pulse, fast rate must stay
		run_speed(pcxt_glue_pkg::speed_slow, 1'b0, pcxt_glue_pkg::CPU_STEP_FAST, 1'b1);
	endtask

	task automatic test_fixed_strobes();
		int n_cpu;
		int n_audio;
		int n_periph;
		count_strobes(100_000, n_cpu, n_audio, n_periph);
		check_count("audio_cen count", expected_pulses(100_000, pcxt_glue_pkg::AUDIO_STEP),
			n_audio);
		check_count("periph_cen count", expected_pulses(100_000, pcxt_glue_pkg::PERIPH_STEP),
			n_periph);
	endtask

	task automatic test_synchronizers();
		int edges;
		int pulses;
		// Data line, then clock line
		ps2_raw.kbd_data = 1'b1;
		tick();
		if (ps2_sync.kbd_data !== 1'b0) report_mismatch("ps2_sync.kbd_data", 0, ps2_sync.kbd_data);
		tick();
		if (ps2_sync.kbd_data !== 1'b1) report_mismatch("ps2_sync.kbd_data", 1, ps2_sync.kbd_data);
		ps2_raw.kbd_clk = 1'b1;
		tick();
		if (ps2_sync.kbd_clk !== 1'b0) report_mismatch("ps2_sync.kbd_clk", 0, ps2_sync.kbd_clk);
		tick();
		if (ps2_sync.kbd_clk !== 1'b1) report_mismatch("ps2_sync.kbd_clk", 1, ps2_sync.kbd_clk);
		// OPL2 reference, 10-cycle period
		edges  = 20;
		pulses = 0;
		repeat (edges) begin
			opl2_ref = 1'b1;
			repeat (5) begin
				tick();
				pulses += int'(opl2_cen);
			end
			opl2_ref = 1'b0;
			repeat (5) begin
				tick();
				pulses += int'(opl2_cen);
			end
		end
		if (pulses != edges) report_mismatch("opl2_cen pulse count", edges, pulses);
	endtask

	task automatic test_bus_glue();
		pcxt_glue_pkg::addr_t addr;
		pcxt_glue_pkg::addr_t prev;
		logic [7:0]           sw_byte;
		logic [3:0]           exp_nibble;
		repeat (8) begin
			addr   = pcxt_glue_pkg::addr_t'($urandom);
			prev   = cpu_address;
			cpu_ad = addr;
			ale    = 1'b0;
			tick();
			if (cpu_address !== prev) report_mismatch("cpu_address without ale", prev, cpu_address);
			ale = 1'b1;
			tick();
			ale    = 1'b0;
			cpu_ad = ~addr;
			if (cpu_address !== addr) report_mismatch("cpu_address", addr, cpu_address);
			repeat (3) tick();
			if (cpu_address !== addr) report_mismatch("cpu_address hold", addr, cpu_address);
		end
		// Switch nibble for each mode and port B bit 3
		for (int mda = 0; mda < 2; mda++) begin
			for (int b3 = 0; b3 < 2; b3++) begin
				port_b            = 8'($urandom);
				port_b[3]         = b3[0];
				settings.mda_mode = mda[0];
				#1;
				sw_byte    = mda ? 8'h3D : 8'h2D;
				exp_nibble = b3 ? sw_byte[7:4] : sw_byte[3:0];
				if (port_c_sw !== exp_nibble) report_mismatch("port_c_sw", exp_nibble, port_c_sw);
			end
		end
		tick();
	endtask

	task automatic test_video_options();
		pcxt_glue_pkg::video_ctrl_t exp;
		logic [2:0]                 mode;
		for (int a = 0; a < 4; a++) begin
			for (int s = 0; s < 4; s++) begin
				for (int m = 0; m < 2; m++) begin
					mode                 = m ? 3'(1 + $urandom % 7) : 3'd0;
					settings.aspect      = a[1:0];
					settings.scale       = s[1:0];
					settings.screen_mode = mode;
					tick();
					exp.arx         = (a == 0) ? 13'd4 : 13'(a - 1);
					exp.ary         = (a == 0) ? 13'd3 : 13'd0;
					exp.scanlines   = {s == 3, s == 2};
					exp.scandoubler = s != 0;
					exp.hq2x        = s == 1;
					exp.color       = mode == 3'd0;
					if (video_ctrl !== exp) report_mismatch("video_ctrl", exp, video_ctrl);
				end
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		CLK_50M            = 1'b0;
		reset_wire         = 1'b1;
		settings           = '0;
		settings.cpu_speed = pcxt_glue_pkg::speed_slow;
		reset_req          = '0;
		bus_idle           = 1'b0;
		ale                = 1'b0;
		opl2_ref           = 1'b0;
		cpu_ad             = '0;
		port_b             = 8'h00;
		ps2_raw            = '0;
		seed               = 73279;
		seed_ret           = $urandom(seed);
		repeat (16) tick();

		test_reset_sequence();
		test_cpu_speed();
		test_fixed_strobes();
		test_synchronizers();
		test_bus_glue();
		test_video_options();

		$display("Run complete after %0d cycles, %0d errors", cycle_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* verif/pcxt_glue_properties.sv */
// PC/XT glue properties: strobe width and reset ordering checks on the top level
`timescale 1ns/1ps

module pcxt_glue_properties (
	input logic CLK_50M,
	input logic reset_wire,
	input logic sys_reset,
	input logic cpu_reset,
	input logic turbo_mode,
	input logic cpu_cen,
	input logic periph_cen,
	input logic audio_cen
);

	////////////////////////////////////////////////////////////////////////////
	// Strobes are single-cycle
	////////////////////////////////////////////////////////////////////////////

	audio_single: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		audio_cen |=> !audio_cen)
		else $error("audio_cen high on two consecutive cycles");

	periph_single: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		periph_cen |=> !periph_cen)
		else $error("periph_cen high on two consecutive cycles");

	cpu_single: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		cpu_cen |=> !cpu_cen)
		else $error("cpu_cen high on two consecutive cycles");

	////////////////////////////////////////////////////////////////////////////
	// Reset ordering
	////////////////////////////////////////////////////////////////////////////

	// CPU stays in reset with the system
	cpu_follows_sys: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		sys_reset |-> cpu_reset)
		else $error("cpu_reset low while sys_reset high");

	// Speed back to 4.77 MHz under reset
	no_turbo_in_reset: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		sys_reset |-> !turbo_mode)
		else $error("turbo_mode high while sys_reset high");

endmodule

bind pcxt_glue_top pcxt_glue_properties u_pcxt_glue_properties (
	.CLK_50M    (CLK_50M),
	.reset_wire (reset_wire),
	.sys_reset  (sys_reset),
	.cpu_reset  (cpu_reset),
	.turbo_mode (turbo_mode),
	.cpu_cen    (cpu_cen),
	.periph_cen (periph_cen),
	.audio_cen  (audio_cen)
);

/* hdl/pcxt_glue_top.sv */
// PC/XT glue top: reset, clock enables, synchronizers, bus glue and video decode
`timescale 1ns/1ps

module pcxt_glue_top (
	input  logic                          CLK_50M,
	input  logic                          reset_wire,
	input  pcxt_glue_pkg::glue_settings_t settings,
	input  pcxt_glue_pkg::reset_req_t     reset_req,
	input  logic                          bus_idle,
	input  logic                          ale,
	input  logic                          opl2_ref,
	input  pcxt_glue_pkg::addr_t          cpu_ad,
	input  logic [7:0]                    port_b,
	input  pcxt_glue_pkg::ps2_lines_t     ps2_raw,
	output logic                          sys_reset,
	output logic                          cpu_reset,
	output logic                          cpu_cen,
	output logic                          turbo_mode,
	output logic                          periph_cen,
	output logic                          audio_cen,
	output logic                          opl2_cen,
	output pcxt_glue_pkg::addr_t          cpu_address,
	output logic [3:0]                    port_c_sw,
	output pcxt_glue_pkg::ps2_lines_t     ps2_sync,
	output pcxt_glue_pkg::video_ctrl_t    video_ctrl
);

	////////////////////////////////////////////////////////////////////////////
	// Reset and clock enables
	////////////////////////////////////////////////////////////////////////////

	reset_sequencer u_reset_sequencer (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.reset_req  (reset_req),
		.sys_reset  (sys_reset),
		.cpu_reset  (cpu_reset)
	);

	// Held slow under every system reset, soft ones included
	cpu_clock_gen u_cpu_clock_gen (
		.CLK_50M    (CLK_50M),
		.reset_wire (sys_reset),
		.settings   (settings),
		.bus_idle   (bus_idle),
		.cpu_cen    (cpu_cen),
		.turbo_mode (turbo_mode)
	);

	// 2.386 MHz peripheral clock
	rate_strobe #(.STEP(pcxt_glue_pkg::PERIPH_STEP)) u_periph_strobe (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.strobe     (periph_cen)
	);

	// 44.1 kHz sample rate
	rate_strobe #(.STEP(pcxt_glue_pkg::AUDIO_STEP)) u_audio_strobe (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.strobe     (audio_cen)
	);

	////////////////////////////////////////////////////////////////////////////
	// Async inputs
	////////////////////////////////////////////////////////////////////////////

	sync_chain #(.data_t(pcxt_glue_pkg::ps2_lines_t)) ps2_in (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.d          (ps2_raw),
		.q          (ps2_sync),
		.rise       ()
	);

	// Rising edge of the reference is the OPL2 enable
	sync_chain #(.data_t(logic)) opl2_in (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.d          (opl2_ref),
		.q          (),
		.rise       (opl2_cen)
	);

	////////////////////////////////////////////////////////////////////////////
	// Bus and video
	////////////////////////////////////////////////////////////////////////////

	cpu_bus_glue u_cpu_bus_glue (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.ale         (ale),
		.cpu_ad      (cpu_ad),
		.port_b      (port_b),
		.settings    (settings),
		.cpu_address (cpu_address),
		.port_c_sw   (port_c_sw)
	);

	video_option_decode u_video_option_decode (
		.settings   (settings),
		.video_ctrl (video_ctrl)
	);

endmodule

/* hdl/video_option_decode.sv */
// Video option decode: aspect ratio, scanlines, scaler select and colour flag
`timescale 1ns/1ps

module video_option_decode (
	input  pcxt_glue_pkg::glue_settings_t settings,
	output pcxt_glue_pkg::video_ctrl_t    video_ctrl
);

	always_comb begin
		////////////////////////////////////////////////////////////////////////
		// Aspect
		////////////////////////////////////////////////////////////////////////
		if (settings.aspect == 2'd0) begin
			// Original 4:3
			video_ctrl.arx = 13'd4;
			video_ctrl.ary = 13'd3;
		end else begin
			// Full screen or custom ratio index
			video_ctrl.arx = {11'd0, settings.aspect - 2'd1};
			video_ctrl.ary = 13'd0;
		end

		////////////////////////////////////////////////////////////////////////
		// Scaler
		////////////////////////////////////////////////////////////////////////

		// 50% mask on bit 1, 25% on bit 0
		video_ctrl.scanlines   = {settings.scale == 2'd3, settings.scale == 2'd2};
		// Any effect needs the doubler
		video_ctrl.scandoubler = settings.scale != 2'd0;
		video_ctrl.hq2x        = settings.scale == 2'd1;

		// Mono tints are nonzero modes
		video_ctrl.color = settings.screen_mode == 3'd0;
	end

endmodule

/* hdl/cpu_bus_glue.sv */
// CPU bus glue: multiplexed address latch and DIP-switch nibble on port C
`timescale 1ns/1ps

module cpu_bus_glue (
	input  logic                          CLK_50M,
	input  logic                          reset_wire,
	input  logic                          ale,
	input  pcxt_glue_pkg::addr_t          cpu_ad,
	input  logic [7:0]                    port_b,
	input  pcxt_glue_pkg::glue_settings_t settings,
	output pcxt_glue_pkg::addr_t          cpu_address,
	output logic [3:0]                    port_c_sw
);

	logic [7:0] sw;

	// Address phase of the AD bus
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_address <= '0;
		end else if (ale) begin
			cpu_address <= cpu_ad;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Switch read
	////////////////////////////////////////////////////////////////////////////

	// MDA 80 col or CGA 80 col, one floppy
	assign sw = settings.mda_mode ? 8'h3D : 8'h2D;

	// Port B bit 3 picks the nibble
	assign port_c_sw = port_b[3] ? sw[7:4] : sw[3:0];

endmodule

/* hdl/cpu_clock_gen.sv */
// CPU clock-enable generator with bus-idle speed latch and turbo flag
`timescale 1ns/1ps

module cpu_clock_gen (
	input  logic                          CLK_50M,
	input  logic                          reset_wire,
	input  pcxt_glue_pkg::glue_settings_t settings,
	input  logic                          bus_idle,
	output logic                          cpu_cen,
	output logic                          turbo_mode
);

	pcxt_glue_pkg::cpu_speed_t active_speed;
	logic [31:0]               step;
	logic [31:0]               acc;
	logic [31:0]               acc_next;

	// Speed change only between bus cycles
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			active_speed <= pcxt_glue_pkg::speed_slow;
		end else if (bus_idle) begin
			active_speed <= settings.cpu_speed;
		end
	end

	// Anything above 4.77 MHz
	assign turbo_mode = (active_speed == pcxt_glue_pkg::speed_mid) ||
		(active_speed == pcxt_glue_pkg::speed_fast);

	// Step table, unused code runs slow
	always_comb begin
		case (active_speed)
			pcxt_glue_pkg::speed_mid:  step = pcxt_glue_pkg::CPU_STEP_MID;
			pcxt_glue_pkg::speed_fast: step = pcxt_glue_pkg::CPU_STEP_FAST;
			default:                   step = pcxt_glue_pkg::CPU_STEP_SLOW;
		endcase
	end

	assign acc_next = acc + step;

	// Fractional divider, one pulse per wrap
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			acc     <= '0;
			cpu_cen <= 1'b0;
		end else if (acc_next >= pcxt_glue_pkg::CLK_HZ) begin
			acc     <= acc_next - pcxt_glue_pkg::CLK_HZ;
			cpu_cen <= 1'b1;
		end else begin
			acc     <= acc_next;
			cpu_cen <= 1'b0;
		end
	end

endmodule

/* hdl/reset_sequencer.sv */
// Reset sequencer: merges reset sources, stretches system reset, delays CPU reset
`timescale 1ns/1ps

module reset_sequencer (
	input  logic                      CLK_50M,
	input  logic                      reset_wire,
	input  pcxt_glue_pkg::reset_req_t reset_req,
	output logic                      sys_reset,
	output logic                      cpu_reset
);

	logic        req_q;
	logic [15:0] stretch_count;
	logic        cpu_sync;
	logic [15:0] cpu_count;

	////////////////////////////////////////////////////////////////////////////
	// System reset
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			req_q         <= 1'b0;
			sys_reset     <= 1'b1;
			stretch_count <= '0;
		end else begin
			// Any soft request
			req_q <= |reset_req;
			if (req_q) begin
				// Restart the stretch
				sys_reset     <= 1'b1;
				stretch_count <= '0;
			end else if (sys_reset) begin
				if (stretch_count != pcxt_glue_pkg::RESET_STRETCH) begin
					stretch_count <= stretch_count + 16'd1;
				end else begin
					sys_reset <= 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// CPU reset
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_sync  <= 1'b1;
			cpu_reset <= 1'b1;
			cpu_count <= '0;
		end else begin
			// Resync of system reset release
			cpu_sync <= sys_reset | req_q;
			// Set together with sys_reset on a soft request
			if (req_q || sys_reset || cpu_sync) begin
				cpu_reset <= 1'b1;
				cpu_count <= '0;
			end else if (cpu_count != pcxt_glue_pkg::CPU_RESET_DELAY) begin
				cpu_count <= cpu_count + 16'd1;
			end else begin
				cpu_reset <= 1'b0;
			end
		end
	end

endmodule

/* hdl/rate_strobe.sv */
// Fixed-rate strobe from a fractional accumulator wrapping at the master clock
`timescale 1ns/1ps

module rate_strobe #(
	// Below CLK_HZ/2 so strobes never touch
	parameter logic [31:0] STEP = pcxt_glue_pkg::AUDIO_STEP
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	output logic strobe
);

	logic [31:0] acc;
	logic [31:0] acc_next;

	assign acc_next = acc + STEP;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			acc    <= '0;
			strobe <= 1'b0;
		end else if (acc_next >= pcxt_glue_pkg::CLK_HZ) begin
			// Wrap, keep the remainder
			acc    <= acc_next - pcxt_glue_pkg::CLK_HZ;
			strobe <= 1'b1;
		end else begin
			acc    <= acc_next;
			strobe <= 1'b0;
		end
	end

endmodule

/* hdl/sync_chain.sv */
// Two-stage synchronizer with per-bit rising-edge pulse
`timescale 1ns/1ps

module sync_chain #(
	parameter type data_t = logic
) (
	input  logic  CLK_50M,
	input  logic  reset_wire,
	input  data_t d,
	output data_t q,
	output data_t rise
);

	data_t meta;
	data_t prev;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			meta <= data_t'('0);
			q    <= data_t'('0);
			prev <= data_t'('0);
		end else begin
			// Metastability pair
			meta <= d;
			q    <= meta;
			// Previous synced value
			prev <= q;
		end
	end

	// High for the first cycle q reads 1
	assign rise = data_t'(q & ~prev);

endmodule

/* hdl/pcxt_glue_pkg.sv */
// PC/XT glue package: clock rates, reset counts, CPU speed steps and shared structs
package pcxt_glue_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Rates and accumulator steps
	////////////////////////////////////////////////////////////////////////////

	// Master clock, modulus of every fractional accumulator
	localparam logic [31:0] CLK_HZ        = 32'd50_000_000;

	// Fixed strobe rates
	localparam logic [31:0] AUDIO_STEP    = 32'd44_100;
	localparam logic [31:0] PERIPH_STEP   = 32'd2_386_364;

	// CPU rates, 4.77 / 7.16 / 14.318 MHz
	localparam logic [31:0] CPU_STEP_SLOW = 32'd4_772_727;
	localparam logic [31:0] CPU_STEP_MID  = 32'd7_159_091;
	localparam logic [31:0] CPU_STEP_FAST = 32'd14_318_182;

	// Reset timing in master cycles
	localparam logic [15:0] RESET_STRETCH   = 16'd65_535;
	localparam logic [15:0] CPU_RESET_DELAY = 16'd42;

	// CPU address bus
	localparam int ADDR_W = 20;

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	// Code 3 unused, treated as slow
	typedef enum logic [1:0] {
		speed_slow = 2'd0,
		speed_mid  = 2'd1,
		speed_fast = 2'd2
	} cpu_speed_t;

	typedef logic [ADDR_W-1:0] addr_t;

	// Menu settings
	typedef struct packed {
		logic       tandy_model;
		logic       mda_mode;
		logic [1:0] scale;        // 0 none, 1 hq2x, 2 CRT 25%, 3 CRT 50%
		logic [1:0] aspect;
		logic [2:0] screen_mode;  // 0 is full colour
		cpu_speed_t cpu_speed;
		logic       adlib_hide;
		logic       ems_disable;
		logic [1:0] ems_frame;
	} glue_settings_t;

	// Soft reset sources, all synchronous
	typedef struct packed {
		logic menu_reset;
		logic user_button;
		logic rom_download;
	} reset_req_t;

	typedef struct packed {
		logic kbd_clk;
		logic kbd_data;
	} ps2_lines_t;

	// Scaler and aspect controls toward the video path
	typedef struct packed {
		logic [12:0] arx;
		logic [12:0] ary;
		logic [1:0]  scanlines;
		logic        scandoubler;
		logic        hq2x;
		logic        color;
	} video_ctrl_t;

endpackage
